/* hdl/cmd_seq_pkg.sv */
// Command sequencer shared definitions
package cmd_seq_pkg;

    // command memory geometry
    localparam logic [11:0] cmd_mem_depth     = 12'd2048;
    localparam int          cmd_mem_add_width = 11;

    // register block sits below the memory in the bus map
    localparam logic [15:0] reg_count     = 16'd8;
    localparam logic [15:0] addr_soft_rst = 16'd0;
    localparam logic [15:0] addr_start    = 16'd1;
    localparam logic [15:0] addr_conf     = 16'd2;
    localparam logic [15:0] addr_size_lo  = 16'd3;
    localparam logic [15:0] addr_size_hi  = 16'd4;
    localparam logic [15:0] addr_rep_lo   = 16'd5;
    localparam logic [15:0] addr_rep_hi   = 16'd6;

    // configuration byte, bit 2 reserved
    localparam int conf_en_ext_start_bit = 0;
    localparam int conf_en_negedge_bit   = 1;
    localparam int conf_dis_pulse_bit    = 3;

    localparam logic [15:0] repeat_default = 16'd1;

    typedef enum logic [0:0] {
        seq_idle = 1'b0,
        seq_send = 1'b1
    } seq_state_t;

    // bus address falls inside the command memory window
    function automatic logic mem_hit(input logic [15:0] addr);
        return (addr >= reg_count) && (addr < reg_count + 16'(cmd_mem_depth));
    endfunction

endpackage

/* hdl/cmd_seq_regs.sv */
// Command sequencer register file
module cmd_seq_regs
    import cmd_seq_pkg::*;
(
    input  logic        CMD_CLK_IN,
    input  logic        RST_CMD_CLK,
    input  logic [15:0] bus_add,
    input  logic [7:0]  bus_data_in,
    input  logic        bus_wr,
    input  logic [7:0]  mem_rd_data,
    input  logic        cmd_ready,
    output logic [7:0]  bus_data_out,
    output logic        seq_rst,
    output logic        start_req,
    output logic [15:0] cmd_size,
    output logic [15:0] repeat_count,
    output logic        en_ext_start,
    output logic        en_negedge,
    output logic        dis_pulse
);

    logic [7:0] regs [8];
    logic       soft_rst;
    logic       rd_mem_q;
    logic [7:0] reg_rd_q;

    // soft reset and start strobes, one cycle after the bus write
    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            soft_rst  <= 1'b0;
            start_req <= 1'b0;
        end else begin
            soft_rst  <= bus_wr && (bus_add == addr_soft_rst);
            start_req <= bus_wr && (bus_add == addr_start);
        end
    end

    assign seq_rst = RST_CMD_CLK | soft_rst;

    always_ff @(posedge CMD_CLK_IN) begin
        if (seq_rst) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= 8'h00;
            end
            regs[addr_rep_lo[2:0]] <= repeat_default[7:0];
            regs[addr_rep_hi[2:0]] <= repeat_default[15:8];
        end else if (bus_wr && (bus_add < reg_count)) begin
            regs[bus_add[2:0]] <= bus_data_in;
        end
    end

    assign cmd_size     = {regs[addr_size_hi[2:0]], regs[addr_size_lo[2:0]]};
    assign repeat_count = {regs[addr_rep_hi[2:0]], regs[addr_rep_lo[2:0]]};
    assign en_ext_start = regs[addr_conf[2:0]][conf_en_ext_start_bit];
    assign en_negedge   = regs[addr_conf[2:0]][conf_en_negedge_bit];
    assign dis_pulse    = regs[addr_conf[2:0]][conf_dis_pulse_bit];

    // read path, memory data is already registered in the memory
    always_ff @(posedge CMD_CLK_IN) begin
        if (RST_CMD_CLK) begin
            rd_mem_q <= 1'b0;
        end else begin
            rd_mem_q <= mem_hit(bus_add);
        end
    end

    always_ff @(posedge CMD_CLK_IN) begin
        if (bus_add == addr_start) begin
            reg_rd_q <= {7'b0, cmd_ready};
        end else if (bus_add < reg_count) begin
            reg_rd_q <= regs[bus_add[2:0]];
        end else begin
            reg_rd_q <= 8'h00;
        end
    end

    assign bus_data_out = rd_mem_q ? mem_rd_data : reg_rd_q;

    // a soft reset never coincides with a start request
    a_start_not_in_reset : assert property (@(posedge CMD_CLK_IN)
        disable iff (RST_CMD_CLK) !(start_req && seq_rst));

endmodule

/* hdl/cmd_seq_mem.sv */
// Command pattern memory
module cmd_seq_mem
    import cmd_seq_pkg::*;
(
    input  logic                         CMD_CLK_IN,
    input  logic [15:0]                  bus_add,
    input  logic [7:0]                   bus_data_in,
    input  logic                         bus_wr,
    input  logic [cmd_mem_add_width-1:0] rd_add,
    output logic [7:0]                   bus_rd_data,
    output logic [7:0]                   rd_data
);

    logic [7:0]  mem [cmd_mem_depth];
    logic [15:0] bus_off;

    // byte k of the memory lives at bus address reg_count + k
    assign bus_off = bus_add - reg_count;

    always_ff @(posedge CMD_CLK_IN) begin
        if (bus_wr && mem_hit(bus_add)) begin
            mem[bus_off[cmd_mem_add_width-1:0]] <= bus_data_in;
        end
    end

    // bus read port
    always_ff @(posedge CMD_CLK_IN) begin
        bus_rd_data <= mem[bus_off[cmd_mem_add_width-1:0]];
    end

    // sequencer read port
    always_ff @(posedge CMD_CLK_IN) begin
        rd_data <= mem[rd_add];
    end

endmodule

/* hdl/cmd_seq_ctrl.sv */
// Command sequencer control FSM
module cmd_seq_ctrl
    import cmd_seq_pkg::*;
(
    input  logic                         CMD_CLK_IN,
    input  logic                         seq_rst,
    input  logic                         start_req,
    input  logic                         cmd_ext_start_flag,
    input  logic                         en_ext_start,
    input  logic [15:0]                  cmd_size,
    input  logic [15:0]                  repeat_count,
    output logic                         cmd_ext_start_enable,
    output logic [cmd_mem_add_width-1:0] rd_add,
    output logic                         load_word,
    output logic                         shift_word,
    output logic                         clear_word,
    output logic                         rep_first,
    output logic                         cmd_ready,
    output seq_state_t                   state
);

    logic        fetch_wait;
    logic [15:0] bit_cnt;
    logic [15:0] rep_cnt;
    logic [15:0] next_bit;
    logic        ext_start;
    logic        accept;
    logic        bit_active;
    logic        last_bit;
    logic        last_rep;

    assign ext_start  = cmd_ext_start_flag & cmd_ext_start_enable;
    assign accept     = (state == seq_idle) && (start_req || ext_start)
                        && (cmd_size != 16'd0);
    // first cycle of send only fetches byte 0
    assign bit_active = (state == seq_send) && !fetch_wait;
    assign last_bit   = bit_active && (bit_cnt == cmd_size - 16'd1);
    // zero repeat count never ends
    assign last_rep   = (repeat_count != 16'd0) && (rep_cnt == repeat_count);
    assign next_bit   = bit_cnt + 16'd1;

    always_ff @(posedge CMD_CLK_IN) begin
        if (seq_rst) begin
            state      <= seq_idle;
            fetch_wait <= 1'b0;
            bit_cnt    <= 16'd0;
            rep_cnt    <= 16'd0;
            clear_word <= 1'b0;
        end else begin
            clear_word <= 1'b0;
            if (accept) begin
                state      <= seq_send;
                fetch_wait <= 1'b1;
                bit_cnt    <= 16'd0;
                rep_cnt    <= 16'd1;
            end else if (state == seq_send) begin
                fetch_wait <= 1'b0;
                if (last_bit) begin
                    bit_cnt <= 16'd0;
                    if (last_rep) begin
                        state      <= seq_idle;
                        clear_word <= 1'b1;
                    end else if (rep_cnt != 16'hffff) begin
                        rep_cnt <= rep_cnt + 16'd1;
                    end
                end else if (bit_active) begin
                    bit_cnt <= next_bit;
                end
            end
        end
    end

    always_ff @(posedge CMD_CLK_IN) begin
        if (seq_rst) begin
            cmd_ready            <= 1'b1;
            cmd_ext_start_enable <= 1'b0;
        end else begin
            cmd_ready            <= (state == seq_idle);
            cmd_ext_start_enable <= en_ext_start;
        end
    end

    // address of the byte needed by the next bit, wraps at end of repetition
    always_comb begin
        if (bit_active && !last_bit) begin
            rd_add = next_bit[cmd_mem_add_width+2:3];
        end else begin
            rd_add = '0;
        end
    end

    assign load_word  = bit_active && (bit_cnt[2:0] == 3'd0);
    assign shift_word = bit_active && (bit_cnt[2:0] != 3'd0);
    assign rep_first  = bit_active && (bit_cnt == 16'd0);

    a_strobe_excl : assert property (@(posedge CMD_CLK_IN)
        !(load_word && shift_word));

    a_idle_after_rst : assert property (@(posedge CMD_CLK_IN)
        seq_rst |=> state == seq_idle);

endmodule

/* hdl/cmd_seq_serializer.sv */
// Command bit serializer
module cmd_seq_serializer
    import cmd_seq_pkg::*;
(
    input  logic       CMD_CLK_IN,
    input  logic       seq_rst,
    input  logic [7:0] rd_data,
    input  logic       load_word,
    input  logic       shift_word,
    input  logic       clear_word,
    input  logic       rep_first,
    input  logic       en_negedge,
    input  logic       dis_pulse,
    input  seq_state_t state,
    output logic       cmd_data,
    output logic       cmd_start_flag
);

    logic [7:0] word;
    logic       data_pos;
    logic       data_neg;
    logic [1:0] rep_pipe;

    // MSB first shift word
    always_ff @(posedge CMD_CLK_IN) begin
        if (seq_rst || clear_word) begin
            word <= 8'h00;
        end else if (load_word) begin
            word <= rd_data;
        end else if (shift_word) begin
            word <= {word[6:0], 1'b0};
        end
    end

    always_ff @(posedge CMD_CLK_IN) begin
        if (seq_rst) begin
            data_pos <= 1'b0;
            rep_pipe <= 2'b00;
        end else begin
            data_pos <= word[7];
            rep_pipe <= {rep_pipe[0], rep_first};
        end
    end

    // half a cycle ahead of the posedge copy
    always_ff @(negedge CMD_CLK_IN) begin
        data_neg <= word[7];
    end

    assign cmd_data       = en_negedge ? data_neg : data_pos;
    assign cmd_start_flag = rep_pipe[1] & ~dis_pulse;

    // flag only for a bit issued while sending
    a_flag_qualified : assert property (@(posedge CMD_CLK_IN) disable iff (seq_rst)
        cmd_start_flag |-> !dis_pulse && ($past(state, 2) == seq_send));

endmodule

/* hdl/cmd_seq_top.sv */
// Serial command sequencer top level
module cmd_seq_top
    import cmd_seq_pkg::*;
(
    input  logic        CMD_CLK_IN,
    input  logic        RST_CMD_CLK,
    input  logic [15:0] bus_add,
    input  logic [7:0]  bus_data_in,
    input  logic        bus_wr,
    input  logic        cmd_ext_start_flag,
    output logic [7:0]  bus_data_out,
    output logic        cmd_data,
    output logic        cmd_start_flag,
    output logic        cmd_ready,
    output logic        cmd_ext_start_enable
);

    logic                         seq_rst;
    logic                         start_req;
    logic [15:0]                  cmd_size;
    logic [15:0]                  repeat_count;
    logic                         en_ext_start;
    logic                         en_negedge;
    logic                         dis_pulse;
    logic [7:0]                   mem_rd_data;
    logic [7:0]                   rd_data;
    logic [cmd_mem_add_width-1:0] rd_add;
    logic                         load_word;
    logic                         shift_word;
    logic                         clear_word;
    logic                         rep_first;
    seq_state_t                   state;

    cmd_seq_regs u_regs (
        .CMD_CLK_IN   (CMD_CLK_IN),
        .RST_CMD_CLK  (RST_CMD_CLK),
        .bus_add      (bus_add),
        .bus_data_in  (bus_data_in),
        .bus_wr       (bus_wr),
        .mem_rd_data  (mem_rd_data),
        .cmd_ready    (cmd_ready),
        .bus_data_out (bus_data_out),
        .seq_rst      (seq_rst),
        .start_req    (start_req),
        .cmd_size     (cmd_size),
        .repeat_count (repeat_count),
        .en_ext_start (en_ext_start),
        .en_negedge   (en_negedge),
        .dis_pulse    (dis_pulse)
    );

    cmd_seq_mem u_mem (
        .CMD_CLK_IN  (CMD_CLK_IN),
        .bus_add     (bus_add),
        .bus_data_in (bus_data_in),
        .bus_wr      (bus_wr),
        .rd_add      (rd_add),
        .bus_rd_data (mem_rd_data),
        .rd_data     (rd_data)
    );

    cmd_seq_ctrl u_ctrl (
        .CMD_CLK_IN           (CMD_CLK_IN),
        .seq_rst              (seq_rst),
        .start_req            (start_req),
        .cmd_ext_start_flag   (cmd_ext_start_flag),
        .en_ext_start         (en_ext_start),
        .cmd_size             (cmd_size),
        .repeat_count         (repeat_count),
        .cmd_ext_start_enable (cmd_ext_start_enable),
        .rd_add               (rd_add),
        .load_word            (load_word),
        .shift_word           (shift_word),
        .clear_word           (clear_word),
        .rep_first            (rep_first),
        .cmd_ready            (cmd_ready),
        .state                (state)
    );

    cmd_seq_serializer u_serializer (
        .CMD_CLK_IN     (CMD_CLK_IN),
        .seq_rst        (seq_rst),
        .rd_data        (rd_data),
        .load_word      (load_word),
        .shift_word     (shift_word),
        .clear_word     (clear_word),
        .rep_first      (rep_first),
        .en_negedge     (en_negedge),
        .dis_pulse      (dis_pulse),
        .state          (state),
        .cmd_data       (cmd_data),
        .cmd_start_flag (cmd_start_flag)
    );

endmodule

/* testbench/tb_cmd_seq.sv */
// Command sequencer testbench
module tb_cmd_seq;
    timeunit 1ns;
    timeprecision 100ps;

    localparam string stim_file = "testbench/cmd_seq_input.txt";
    localparam int    ready_wait_max = 16;

    logic        CMD_CLK_IN;
    logic        RST_CMD_CLK;
    logic [15:0] bus_add;
    logic [7:0]  bus_data_in;
    logic        bus_wr;
    logic        cmd_ext_start_flag;
    logic [7:0]  bus_data_out;
    logic        cmd_data;
    logic        cmd_start_flag;
    logic        cmd_ready;
    logic        cmd_ext_start_enable;

    // shadow of everything written over the bus
    logic [7:0] shadow_mem [2048];
    logic [7:0] shadow_regs [8];
    int         errors = 0;
    int         active_checks = 0;
    bit         sending = 0;
    longint     timeout_ns = 0;

    cmd_seq_top UUT (
        .CMD_CLK_IN           (CMD_CLK_IN),
        .RST_CMD_CLK          (RST_CMD_CLK),
        .bus_add              (bus_add),
        .bus_data_in          (bus_data_in),
        .bus_wr               (bus_wr),
        .cmd_ext_start_flag   (cmd_ext_start_flag),
        .bus_data_out         (bus_data_out),
        .cmd_data             (cmd_data),
        .cmd_start_flag       (cmd_start_flag),
        .cmd_ready            (cmd_ready),
        .cmd_ext_start_enable (cmd_ext_start_enable)
    );

    initial CMD_CLK_IN = 1'b0;
    always #4 CMD_CLK_IN = ~CMD_CLK_IN;

    task automatic compare_values(input logic [15:0] actual, input logic [15:0] expected,
                                  input string msg);
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t ns: %s, got %h expected %h", $time, msg, actual, expected);
        end
    endtask

    function automatic void reset_shadow_regs();
        for (int i = 0; i < 8; i++) begin
            shadow_regs[i] = 8'h00;
        end
        shadow_regs[5] = 8'h01;
    endfunction

    // bit i of a repetition in MSB first order
    function automatic logic expected_bit(input int i);
        logic [7:0] b;
        b = shadow_mem[i / 8];
        return b[7 - (i % 8)];
    endfunction

    function automatic int shadow_size();
        return int'({shadow_regs[4], shadow_regs[3]});
    endfunction

    function automatic int shadow_repeat();
        return int'({shadow_regs[6], shadow_regs[5]});
    endfunction

    // all bus tasks start and end 1 ns after a rising edge
    task automatic bus_write(input int a, input int d);
        bus_add     = 16'(a);
        bus_data_in = 8'(d);
        bus_wr      = 1'b1;
        @(posedge CMD_CLK_IN);
        #1;
        bus_wr = 1'b0;
        if (a < 8) begin
            shadow_regs[a] = 8'(d);
        end else if (a < 2056) begin
            shadow_mem[a - 8] = 8'(d);
        end
        if (a == 0) begin
            reset_shadow_regs();
            sending = 0;
            repeat (3) @(posedge CMD_CLK_IN);
            #1;
            compare_values(16'(cmd_data), 16'd0, "cmd_data after soft reset");
            compare_values(16'(cmd_ready), 16'd1, "cmd_ready after soft reset");
            compare_values(16'(cmd_start_flag), 16'd0, "start flag after soft reset");
            compare_values(16'(cmd_ext_start_enable), 16'd0, "ext enable after soft reset");
        end else if (a == 2) begin
            @(posedge CMD_CLK_IN);
            #1;
            compare_values(16'(cmd_ext_start_enable), 16'(d & 1), "cmd_ext_start_enable");
        end
    endtask

    task automatic bus_read(input int a, input int expected);
        bus_add = 16'(a);
        bus_wr  = 1'b0;
        @(posedge CMD_CLK_IN);
        #1;
        compare_values(16'(bus_data_out), 16'(expected), $sformatf("read of address %h", a));
    endtask

    // first_edges counts rising edges up to the slot of bit 0
    task automatic check_stream(input int first_edges);
        int   size;
        int   rep;
        int   total;
        int   idx;
        int   waited;
        logic neg;
        logic dis;
        logic exp_bit;
        size  = shadow_size();
        rep   = shadow_repeat();
        neg   = shadow_regs[2][1];
        dis   = shadow_regs[2][3];
        // endless mode is checked over three repetitions
        total = (rep == 0) ? size * 3 : size * rep;
        repeat (first_edges - 1) @(posedge CMD_CLK_IN);
        for (int k = 0; k < total; k++) begin
            idx     = k % size;
            exp_bit = expected_bit(idx);
            if (neg) begin
                @(negedge CMD_CLK_IN);
                #1;
                compare_values(16'(cmd_data), 16'(exp_bit), $sformatf("negedge bit %0d", k));
            end
            @(posedge CMD_CLK_IN);
            #2;
            if (!neg) begin
                compare_values(16'(cmd_data), 16'(exp_bit), $sformatf("stream bit %0d", k));
            end
            compare_values(16'(cmd_start_flag), 16'(!dis && idx == 0),
                           $sformatf("start flag at bit %0d", k));
        end
        if (rep != 0) begin
            @(posedge CMD_CLK_IN);
            #2;
            compare_values(16'(cmd_data), 16'd0, "cmd_data after last bit");
            compare_values(16'(cmd_start_flag), 16'd0, "start flag after last bit");
            // ready comes back some cycles after the last bit
            waited = 0;
            while (cmd_ready !== 1'b1 && waited < ready_wait_max) begin
                @(posedge CMD_CLK_IN);
                #2;
                waited++;
            end
            if (cmd_ready !== 1'b1) begin
                errors++;
                $display("cmd_ready stayed low %0d cycles after the stream", ready_wait_max);
            end
            sending = 0;
        end
        active_checks--;
    endtask

    task automatic launch_stream(input int first_edges);
        sending = 1;
        active_checks++;
        fork
            check_stream(first_edges);
        join_none
    endtask

    task automatic soft_start();
        bit accepted;
        accepted    = !sending && shadow_size() != 0;
        bus_add     = 16'd1;
        bus_data_in = 8'h00;
        bus_wr      = 1'b1;
        @(posedge CMD_CLK_IN);
        #1;
        bus_wr = 1'b0;
        // start_req is sampled one edge after the write
        if (accepted) begin
            launch_stream(4);
        end
    endtask

    task automatic ext_start();
        bit accepted;
        accepted = !sending && shadow_size() != 0 && shadow_regs[2][0];
        cmd_ext_start_flag = 1'b1;
        @(posedge CMD_CLK_IN);
        #1;
        cmd_ext_start_flag = 1'b0;
        if (accepted) begin
            launch_stream(3);
        end else if (!sending) begin
            // the sequencer must stay idle with a quiet output
            for (int k = 0; k < 4; k++) begin
                @(posedge CMD_CLK_IN);
                #1;
                compare_values(16'(cmd_ready), 16'd1, "ready after ignored ext start");
                compare_values(16'(cmd_data), 16'd0, "cmd_data after ignored ext start");
            end
        end
    endtask

    // run length estimate for the watchdog
    task automatic estimate_timeout();
        int    fd;
        int    a;
        int    b;
        int    size;
        int    rep;
        longint cycles;
        string line;
        size   = 0;
        rep    = 1;
        cycles = 100;
        fd = $fopen(stim_file, "r");
        if (fd == 0) begin
            timeout_ns = 1000;
            return;
        end
        while ($fgets(line, fd) > 0) begin
            a = 0;
            b = 0;
            if (line.len() > 1) begin
                void'($sscanf(line.substr(1, line.len() - 1), "%h %h", a, b));
            end
            if (line[0] == "W") begin
                if (a == 0) begin
                    size = 0;
                    rep  = 1;
                end
                if (a == 3) size = (size & 'hff00) | b;
                if (a == 4) size = (size & 'h00ff) | (b << 8);
                if (a == 5) rep = (rep & 'hff00) | b;
                if (a == 6) rep = (rep & 'h00ff) | (b << 8);
                cycles += 8;
            end else if (line[0] == "S" || line[0] == "X") begin
                cycles += ((rep == 0) ? size * 3 : size * rep) + 10;
            end else if (line[0] == "N") begin
                cycles += a;
            end else begin
                cycles += 4;
            end
        end
        $fclose(fd);
        timeout_ns = cycles * 4 * 8;
    endtask

    initial begin
        wait (timeout_ns > 0);
        #(timeout_ns);
        $display("timeout: the run did not finish within %0d ns", timeout_ns);
        $display("Test failed");
        $finish;
    end

    initial begin
        int    fd;
        int    a;
        int    b;
        string line;
        RST_CMD_CLK        = 1'b1;
        bus_add            = 16'd0;
        bus_data_in        = 8'h00;
        bus_wr             = 1'b0;
        cmd_ext_start_flag = 1'b0;
        reset_shadow_regs();
        estimate_timeout();
        repeat (8) @(posedge CMD_CLK_IN);
        #1;
        RST_CMD_CLK = 1'b0;
        compare_values(16'(cmd_ready), 16'd1, "cmd_ready after reset");
        compare_values(16'(cmd_data), 16'd0, "cmd_data after reset");
        compare_values(16'(cmd_start_flag), 16'd0, "start flag after reset");
        compare_values(16'(cmd_ext_start_enable), 16'd0, "ext enable after reset");
        fd = $fopen(stim_file, "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the stimulus file %s", stim_file);
        end else begin
            while ($fgets(line, fd) > 0) begin
                a = 0;
                b = 0;
                if (line.len() > 1) begin
                    void'($sscanf(line.substr(1, line.len() - 1), "%h %h", a, b));
                end
                case (line[0])
                    "W": bus_write(a, b);
                    "R": bus_read(a, b);
                    "S": soft_start();
                    "X": ext_start();
                    "N": begin
                        repeat (a) @(posedge CMD_CLK_IN);
                        #1;
                    end
                    "#", "\n", " ": ;
                    default: begin
                        errors++;
                        $display("unknown command in the stimulus file: %s", line);
                    end
                endcase
            end
            $fclose(fd);
        end
        wait (active_checks == 0);
        $display("run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* testbench/cmd_seq_input.txt */
# W addr data | R addr expected | S soft start | X ext start pulse | N cycles
# addresses and data in hex, N count in hex
R 0005 01
R 0001 01
R 0002 00
R 0003 00
R 0006 00
W 0008 a5
W 0009 3c
W 000a f0
W 0003 13
W 0005 03
R 0008 a5
R 000a f0
R 0003 13
R 0005 03
S
N 50
R 0001 01
W 0002 08
S
N 50
W 0002 02
S
N 50
W 0002 00
X
N 5
W 0002 01
X
N a
S
N 50
W 0005 00
S
N 50
W 0000 00
R 0005 01
R 0003 00
R 0002 00
R 0001 01
R 0008 a5

/* filelist.f */
hdl/cmd_seq_pkg.sv
hdl/cmd_seq_regs.sv
hdl/cmd_seq_mem.sv
hdl/cmd_seq_ctrl.sv
hdl/cmd_seq_serializer.sv
hdl/cmd_seq_top.sv
testbench/tb_cmd_seq.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_cmd_seq
FILELIST = filelist.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with $(SIM)"
	@echo "  clean  remove build output"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Test passed"

clean:
	rm -rf $(OBJ_DIR)
